// ==== i2c_init_pkg.sv ====
/*
 * shared constants and types for the I2C sensor initializer
 * DEV_ID and SCL_HALF are fixed here, with no per-instance override
 * opcodes 06 and 07 are not part of opcode_e and decode as no-ops
 */
package i2c_init_pkg;

    // 7-bit target address, sent with write bit 0
    localparam logic [6:0] DEV_ID = 7'h35;

    // system clocks per SCL half-period
    localparam int SCL_HALF = 60;

    localparam int ROM_WORDS = 512;
    localparam string PROGRAM_FILE = "seq_input.hex";

    // eight data bits plus the acknowledge slot
    localparam int BITS_PER_SLOT = 9;

    typedef logic [15:0] pc_t;
    typedef logic [8:0] rom_addr_t;
    typedef logic [31:0] word_t;
    typedef logic [15:0] reg_addr_t;
    typedef logic [7:0] reg_data_t;
    typedef logic [7:0] trig_t;
    typedef logic [23:0] arg_t;

    typedef enum logic [7:0] {
        TX = 8'h00,
        WAIT = 8'h01,
        TRIG = 8'h02,
        SET_TRIG = 8'h03,
        JMP_REL = 8'h04,
        JMP = 8'h05
    } opcode_e;

    // instruction word, opcode in the top byte
    typedef struct packed {
        opcode_e opcode;
        arg_t arg;
    } instr_t;

    // one register write handed to the I2C master
    typedef struct packed {
        reg_addr_t reg_addr;
        reg_data_t reg_data;
    } i2c_cmd_t;

    // single-cycle pulses at each SCL half-period boundary
    typedef struct packed {
        logic rise;
        logic fall;
    } scl_tick_t;

endpackage

// ==== scl_tick_gen.sv ====
/*
 * SCL half-period tick generator
 * rise and fall alternate every SCL_HALF clocks, starting with rise after reset
 */
`timescale 1ns/10ps

module scl_tick_gen
    import i2c_init_pkg::*;
(
    input logic clock,
    input logic reset,
    output scl_tick_t tick_o
);

    logic [$clog2(SCL_HALF)-1:0] half_cnt;
    logic phase;
    logic wrap;

    assign wrap = (half_cnt == $bits(half_cnt)'(SCL_HALF - 1));

    always_ff @(posedge clock) begin
        if (reset) begin
            half_cnt <= '0;
            phase <= 1'b0;
            tick_o <= '0;
        end else begin
            tick_o <= '0;
            if (wrap) begin
                half_cnt <= '0;
                phase <= ~phase;
                // phase low means the virtual clock is about to go high
                tick_o.rise <= ~phase;
                tick_o.fall <= phase;
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== i2c_write_master.sv ====
/*
 * I2C write master, one register write per four-phase req/ack handshake
 * frame is START, {DEV_ID,0}, reg_addr high, reg_addr low, reg_data, STOP
 * acknowledge slots leave SDA released and are never sampled
 * sda_o and scl_o are open-drain levels, 1 means released
 */
`timescale 1ns/10ps

module i2c_write_master
    import i2c_init_pkg::*;
(
    input logic clock,
    input logic reset,
    input scl_tick_t tick_i,
    input logic req_i,
    input i2c_cmd_t cmd_i,
    output logic ack_o,
    output logic sda_o,
    output logic scl_o
);

    typedef enum logic [2:0] {
        IDLE,
        PRE_START,
        START,
        SHIFT,
        STOP,
        DONE
    } state_e;

    state_e state;

    // bit slot within a byte, reused as the step counter during STOP
    logic [3:0] bit_cnt;
    logic [1:0] byte_cnt;

    // address byte followed by the command, shifted out MSB first
    logic [31:0] frame;

    logic ack_slot;

    assign ack_slot = (bit_cnt == 4'(BITS_PER_SLOT - 1));

    always_ff @(posedge clock) begin
        if (state == IDLE && req_i) begin
            frame <= {DEV_ID, 1'b0, cmd_i};
        end else if (state == SHIFT && tick_i.fall && !ack_slot) begin
            frame <= {frame[30:0], 1'b0};
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= IDLE;
            bit_cnt <= '0;
            byte_cnt <= '0;
            ack_o <= 1'b0;
            sda_o <= 1'b1;
            scl_o <= 1'b1;
        end else begin
            case (state)
                IDLE: begin
                    sda_o <= 1'b1;
                    scl_o <= 1'b1;
                    if (req_i) begin
                        state <= PRE_START;
                    end
                end

                // line up with the SCL phase before the START
                PRE_START: begin
                    if (tick_i.fall) begin
                        state <= START;
                    end
                end

                START: begin
                    if (tick_i.rise) begin
                        // SDA falls while SCL is high
                        sda_o <= 1'b0;
                        bit_cnt <= '0;
                        byte_cnt <= '0;
                        state <= SHIFT;
                    end
                end

                SHIFT: begin
                    if (tick_i.fall) begin
                        scl_o <= 1'b0;
                        sda_o <= ack_slot ? 1'b1 : frame[31];
                    end
                    if (tick_i.rise) begin
                        scl_o <= 1'b1;
                        if (ack_slot) begin
                            bit_cnt <= '0;
                            byte_cnt <= byte_cnt + 1'b1;
                            if (byte_cnt == 2'd3) begin
                                state <= STOP;
                            end
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end

                // step 0 pulls both low, step 1 releases SCL, step 2 releases SDA
                STOP: begin
                    if (tick_i.fall && bit_cnt == 4'd0) begin
                        scl_o <= 1'b0;
                        sda_o <= 1'b0;
                        bit_cnt <= 4'd1;
                    end else if (tick_i.rise && bit_cnt == 4'd1) begin
                        scl_o <= 1'b1;
                        bit_cnt <= 4'd2;
                    end else if (tick_i.fall && bit_cnt == 4'd2) begin
                        sda_o <= 1'b1;
                        bit_cnt <= '0;
                        ack_o <= 1'b1;
                        state <= DONE;
                    end
                end

                // hold ack until the requester lets go of req
                DONE: begin
                    if (!req_i) begin
                        ack_o <= 1'b0;
                        state <= IDLE;
                    end
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// ==== program_rom.sv ====
/*
 * instruction ROM, contents loaded from PROGRAM_FILE at elaboration
 * read data appears one clock after the address
 */
`timescale 1ns/10ps

module program_rom
    import i2c_init_pkg::*;
(
    input logic clock,
    input rom_addr_t addr_i,
    output word_t data_o
);

    word_t mem [ROM_WORDS];

    initial begin
        $readmemh(PROGRAM_FILE, mem);
    end

    // registered read so the array maps onto block RAM
    always_ff @(posedge clock) begin
        data_o <= mem[addr_i];
    end

endmodule

// ==== init_sequencer.sv ====
/*
 * program sequencer, FETCH then LOAD then one or more EXECUTE cycles
 * TX stalls in EXECUTE until the master's ack has dropped again
 * pc is 16 bits but only the low 9 address the ROM
 */
`timescale 1ns/10ps

module init_sequencer
    import i2c_init_pkg::*;
(
    input logic clock,
    input logic reset,
    output rom_addr_t rom_addr_o,
    input word_t rom_data_i,
    input trig_t trig_i,
    output trig_t trig_o,
    output logic req_o,
    output i2c_cmd_t cmd_o,
    input logic ack_i
);

    typedef enum logic [1:0] {
        FETCH,
        LOAD,
        EXECUTE
    } state_e;

    state_e state;
    pc_t pc;
    instr_t ir;
    arg_t cycle_cnt;
    trig_t trig_q;

    // set once the handshake has seen ack, cleared on the next LOAD
    logic tx_sent;
    logic tx_launch;
    logic trig_hit;

    assign rom_addr_o = pc[8:0];

    assign tx_launch = (state == EXECUTE) && (ir.opcode == TX) && !req_o && !tx_sent && !ack_i;

    // arg[7:0] waits for high inputs, arg[15:8] for low inputs
    assign trig_hit = |(ir.arg[7:0] & trig_q) || |(ir.arg[15:8] & ~trig_q);

    always_ff @(posedge clock) begin
        trig_q <= trig_i;
        if (state == LOAD) begin
            ir <= instr_t'(rom_data_i);
        end
        if (tx_launch) begin
            cmd_o <= i2c_cmd_t'(ir.arg);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= FETCH;
            pc <= '0;
            cycle_cnt <= '0;
            trig_o <= '0;
            req_o <= 1'b0;
            tx_sent <= 1'b0;
        end else begin
            case (state)
                // ROM address is presented from pc this cycle
                FETCH: begin
                    state <= LOAD;
                end

                LOAD: begin
                    pc <= pc + 1'b1;
                    cycle_cnt <= '0;
                    tx_sent <= 1'b0;
                    state <= EXECUTE;
                end

                EXECUTE: begin
                    cycle_cnt <= cycle_cnt + 1'b1;
                    case (ir.opcode)
                        TX: begin
                            if (tx_launch) begin
                                req_o <= 1'b1;
                            end else if (req_o && ack_i) begin
                                req_o <= 1'b0;
                                tx_sent <= 1'b1;
                            end else if (tx_sent && !ack_i) begin
                                state <= FETCH;
                            end
                        end

                        WAIT: begin
                            if (cycle_cnt >= ir.arg) begin
                                state <= FETCH;
                            end
                        end

                        TRIG: begin
                            if (trig_hit) begin
                                state <= FETCH;
                            end
                        end

                        SET_TRIG: begin
                            trig_o <= ir.arg[7:0];
                            state <= FETCH;
                        end

                        // pc already points past the jump
                        JMP_REL: begin
                            pc <= pc + ir.arg[15:0];
                            state <= FETCH;
                        end

                        JMP: begin
                            pc <= ir.arg[15:0];
                            state <= FETCH;
                        end

                        default: begin
                            state <= FETCH;
                        end
                    endcase
                end

                default: begin
                    state <= FETCH;
                end
            endcase
        end
    end

endmodule

// ==== i2c_init_top.sv ====
/*
 * sensor initializer top, program ROM driving an I2C write master
 * sda_o and scl_o are open-drain levels, the board wrapper builds the pads
 */
`timescale 1ns/10ps

module i2c_init_top
    import i2c_init_pkg::*;
(
    input logic clock,
    input logic reset,
    input trig_t trig_i,
    output trig_t trig_o,
    output logic sda_o,
    output logic scl_o
);

    scl_tick_t tick;
    rom_addr_t rom_addr;
    word_t rom_data;
    i2c_cmd_t cmd;
    logic req;
    logic ack;

    scl_tick_gen u_tick_gen (
        .clock(clock),
        .reset(reset),
        .tick_o(tick)
    );

    program_rom u_rom (
        .clock(clock),
        .addr_i(rom_addr),
        .data_o(rom_data)
    );

    init_sequencer u_sequencer (
        .clock(clock),
        .reset(reset),
        .rom_addr_o(rom_addr),
        .rom_data_i(rom_data),
        .trig_i(trig_i),
        .trig_o(trig_o),
        .req_o(req),
        .cmd_o(cmd),
        .ack_i(ack)
    );

    i2c_write_master u_master (
        .clock(clock),
        .reset(reset),
        .tick_i(tick),
        .req_i(req),
        .cmd_i(cmd),
        .ack_o(ack),
        .sda_o(sda_o),
        .scl_o(scl_o)
    );

endmodule

// ==== i2c_bus_monitor.sv ====
/*
 * I2C bus decoder for the open-drain bus levels, 1 means released
 * samples on the falling system clock, where the DUT outputs are stable
 * a partial slot before STOP is dropped
 */
`timescale 1ns/10ps

module i2c_bus_monitor
    import i2c_init_pkg::*;
(
    input logic clock,
    input logic sda_i,
    input logic scl_i
);

    int start_count = 0;
    int stop_count = 0;

    // each slot holds the byte in [8:1] and the ack level in [0]
    logic [8:0] slots [$];

    logic [8:0] shreg = '0;
    int bit_cnt = 0;
    logic sda_q = 1'b1;
    logic scl_q = 1'b1;

    always @(negedge clock) begin
        if (scl_q && scl_i && sda_q && !sda_i) begin
            start_count++;
            bit_cnt = 0;
        end else if (scl_q && scl_i && !sda_q && sda_i) begin
            stop_count++;
            bit_cnt = 0;
        end else if (!scl_q && scl_i) begin
            // data is valid while SCL is high
            shreg = {shreg[7:0], sda_i};
            bit_cnt++;
            if (bit_cnt == BITS_PER_SLOT) begin
                slots.push_back(shreg);
                bit_cnt = 0;
            end
        end
        sda_q = sda_i;
        scl_q = scl_i;
    end

endmodule

// ==== tb_i2c_init.sv ====
/*
 * testbench for i2c_init_top, expected events come from walking seq_input.hex
 * the program must end in a jump to its own address
 * trigger waits are released after a random 50 to 300 cycles
 */
`timescale 1ns/10ps

module tb_i2c_init
    import i2c_init_pkg::*;
();

    typedef enum logic [1:0] {
        EV_FRAME,
        EV_SET,
        EV_TRIG
    } ev_kind_e;

    typedef struct packed {
        ev_kind_e kind;
        arg_t value;
        logic [31:0] min_gap;
    } exp_event_t;

    logic clock = 1'b0;
    logic reset = 1'b1;
    trig_t trig_i = 8'hf0;
    trig_t trig_o;
    logic sda_o;
    logic scl_o;

    word_t prog [ROM_WORDS];
    exp_event_t events [$];
    int errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int trig_changes = 0;
    longint last_trig_time = 0;
    logic [31:0] rng_state = 32'hc7b6;
    longint limit_cycles = 0;
    logic model_ready = 1'b0;

    i2c_init_top uut (
        .clock(clock),
        .reset(reset),
        .trig_i(trig_i),
        .trig_o(trig_o),
        .sda_o(sda_o),
        .scl_o(scl_o)
    );

    i2c_bus_monitor mon (
        .clock(clock),
        .sda_i(sda_o),
        .scl_i(scl_o)
    );

    always #5 clock = ~clock;

    always @(trig_o) begin
        if (!reset) begin
            trig_changes++;
            last_trig_time = $time;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t %s: got %0h, expected %0h", $time, name, actual, expected);
            errors++;
        end
    endtask

    task automatic report_test(input string desc, input int errs_before);
        if (errors == errs_before) begin
            tests_passed++;
            $display("test %s: ok", desc);
        end else begin
            tests_failed++;
            $display("test %s: failed", desc);
        end
    endtask

    // walk the program the way the sequencer executes it
    task automatic build_model();
        pc_t pc;
        arg_t arg;
        trig_t cur_trig;
        exp_event_t ev;
        longint gap_acc;
        longint tx_count;
        longint wait_sum;
        longint trig_count;
        int steps;
        logic halted;
        pc = '0;
        cur_trig = '0;
        gap_acc = 0;
        tx_count = 0;
        wait_sum = 0;
        trig_count = 0;
        steps = 0;
        halted = 1'b0;
        // gap_acc counts FETCH, LOAD and the shortest EXECUTE of each instruction
        while (!halted && steps < 4 * ROM_WORDS) begin
            arg = prog[pc[8:0]][23:0];
            steps++;
            case (prog[pc[8:0]][31:24])
                8'h00: begin
                    // req rises after the TX fetch, START waits a fall and then a rise
                    ev = '{EV_FRAME, arg, 32'(gap_acc + 3 + SCL_HALF)};
                    events.push_back(ev);
                    gap_acc = 0;
                    tx_count++;
                    pc = pc + 16'd1;
                end
                8'h01: begin
                    gap_acc += 2 + longint'(arg) + 1;
                    wait_sum += longint'(arg);
                    pc = pc + 16'd1;
                end
                8'h02: begin
                    ev = '{EV_TRIG, arg, 32'd0};
                    events.push_back(ev);
                    trig_count++;
                    gap_acc += 3;
                    pc = pc + 16'd1;
                end
                8'h03: begin
                    // only a real change of trig_o is visible
                    if (arg[7:0] != cur_trig) begin
                        ev = '{EV_SET, arg, 32'd0};
                        events.push_back(ev);
                        cur_trig = arg[7:0];
                        gap_acc = 0;
                    end else begin
                        gap_acc += 3;
                    end
                    pc = pc + 16'd1;
                end
                8'h04: begin
                    gap_acc += 3;
                    pc = pc + 16'd1 + arg[15:0];
                end
                8'h05: begin
                    if (arg[15:0] == pc) begin
                        halted = 1'b1;
                    end else begin
                        gap_acc += 3;
                        pc = arg[15:0];
                    end
                end
                default: begin
                    gap_acc += 3;
                    pc = pc + 16'd1;
                end
            endcase
        end
        if (!halted) begin
            $display("program model found no halt jump within %0d steps", steps);
            errors++;
        end
        limit_cycles = 2 * (tx_count * 45 * 2 * SCL_HALF + wait_sum + 300 * trig_count);
    endtask

    task automatic check_frame(input arg_t cmd, input int idx);
        logic [7:0] exp_bytes [4];
        logic [8:0] slot;
        int b;
        exp_bytes[0] = {DEV_ID, 1'b0};
        exp_bytes[1] = cmd[23:16];
        exp_bytes[2] = cmd[15:8];
        exp_bytes[3] = cmd[7:0];
        if (mon.slots.size() != 4) begin
            $display("frame %0d carried %0d byte slots instead of 4", idx, mon.slots.size());
            errors++;
        end
        for (b = 0; b < 4 && mon.slots.size() > 0; b++) begin
            slot = mon.slots.pop_front();
            check_value($sformatf("frame %0d byte %0d", idx, b), 32'(slot[8:1]),
                        32'(exp_bytes[b]));
            check_value($sformatf("frame %0d ack slot %0d", idx, b), 32'(slot[0]), 32'd1);
        end
        mon.slots.delete();
    endtask

    initial begin
        wait (model_ready);
        repeat (limit_cycles) @(posedge clock);
        $display("watchdog expired after %0d cycles, the DUT stopped making progress",
                 limit_cycles);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        exp_event_t ev;
        int exp_changes;
        int exp_frames;
        int errs_before;
        int delay;
        int changes0;
        int starts0;
        longint elapsed;
        string desc;
        $readmemh(PROGRAM_FILE, prog);
        build_model();
        model_ready = 1'b1;
        exp_changes = 0;
        exp_frames = 0;

        repeat (3) @(posedge clock);
        #1;
        reset = 1'b0;
        errs_before = errors;
        check_value("sda_o", 32'(sda_o), 32'd1);
        check_value("scl_o", 32'(scl_o), 32'd1);
        check_value("trig_o", 32'(trig_o), 32'd0);
        report_test("reset state", errs_before);

        foreach (events[i]) begin
            ev = events[i];
            errs_before = errors;
            case (ev.kind)
                EV_SET: begin
                    wait (trig_changes == exp_changes + 1);
                    exp_changes++;
                    check_value("trig_o", 32'(trig_o), 32'(ev.value[7:0]));
                    check_value("START count at trig_o change", mon.start_count, exp_frames);
                    desc = $sformatf("%0d trig_o set to %02h", i, ev.value[7:0]);
                end
                EV_FRAME: begin
                    wait (mon.start_count == exp_frames + 1);
                    check_value("trig_o change count at START", trig_changes, exp_changes);
                    elapsed = longint'($time - last_trig_time) / 10;
                    if (elapsed < longint'(ev.min_gap)) begin
                        $display("START came %0d cycles after the trig_o change, expected at least %0d",
                                 elapsed, ev.min_gap);
                        errors++;
                    end
                    wait (mon.stop_count == exp_frames + 1);
                    check_frame(ev.value, exp_frames);
                    exp_frames++;
                    desc = $sformatf("%0d frame %04h <= %02h", i, ev.value[23:8],
                                     ev.value[7:0]);
                end
                default: begin
                    starts0 = mon.start_count;
                    changes0 = trig_changes;
                    if (|(ev.value[7:0] & trig_i) || |(ev.value[15:8] & ~trig_i)) begin
                        $display("trigger wait %0d is already met by trig_i %02h", i, trig_i);
                        errors++;
                    end
                    rng_state = xorshift(rng_state);
                    delay = 50 + int'(rng_state % 32'd251);
                    repeat (delay) @(posedge clock);
                    #1;
                    check_value("START count during trigger wait", mon.start_count, starts0);
                    check_value("trig_o changes during trigger wait", trig_changes, changes0);
                    trig_i = (trig_i | ev.value[7:0]) & ~ev.value[15:8];
                    desc = $sformatf("%0d trigger wait released after %0d cycles", i, delay);
                end
            endcase
            report_test(desc, errs_before);
        end

        // the sequencer sits on the halt jump from here on
        errs_before = errors;
        repeat (4 * 2 * SCL_HALF) @(posedge clock);
        check_value("START count after halt", mon.start_count, exp_frames);
        check_value("trig_o changes after halt", trig_changes, exp_changes);
        check_value("byte slots after halt", mon.slots.size(), 0);
        check_value("sda_o after halt", 32'(sda_o), 32'd1);
        check_value("scl_o after halt", 32'(scl_o), 32'd1);
        report_test("halt keeps the bus idle", errs_before);

        $display("tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
i2c_init_pkg.sv
scl_tick_gen.sv
i2c_write_master.sv
program_rom.sv
init_sequencer.sv
i2c_init_top.sv
i2c_bus_monitor.sv
tb_i2c_init.sv

// ==== run.sh ====
#!/bin/sh
# compile the testbench with Verilator and run it from the project root
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_i2c_init

./obj_dir/Vtb_i2c_init | tee sim.log

if grep -q "Result: FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

if ! grep -q "Result: PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

echo "simulation passed"

// ==== seq_input.hex ====
// one instruction per line: opcode byte, then the 24-bit argument
// 00 TX {reg_addr, reg_data}, 01 WAIT, 02 TRIG {low mask, high mask}, 03 SET_TRIG, 04/05 jumps
03000001 // trig_o <= 01
01000064 // wait 100
00301a5c // write 5c to 301a
02000001 // wait for trig_i[0] high
00310b22 // write 22 to 310b
04000001 // relative jump over the next word
00dead00 // never sent
03000080 // trig_o <= 80
01000032 // wait 50
0500000b // jump to 11
000bad00 // never sent
00302e01 // write 01 to 302e
02008000 // wait for trig_i[7] low
03000000 // trig_o <= 00
00300042 // write 42 to 3000
0500000f // halt
